/* common/ara_settings.svh */
`ifndef ARA_SETTINGS_SVH
`define ARA_SETTINGS_SVH

//////////////////////////////////////////////////
// Cluster topology
//////////////////////////////////////////////////

// Number of vector clusters, a power of two
`define ARA_NR_CLUSTERS 8
// Depth of the fork and join trees, log2 of the cluster count
`define ARA_TREE_LEVELS 3

//////////////////////////////////////////////////
// Host interface widths
//////////////////////////////////////////////////

`define ARA_INSN_WIDTH 32
`define ARA_DATA_WIDTH 32
`define ARA_TAG_WIDTH 4

`endif

/* common/acc_pkg.sv */
`default_nettype none

`include "ara_settings.svh"

// Types seen on the host side of the dispatcher
package acc_pkg;

  typedef logic [`ARA_INSN_WIDTH-1:0] insn_t;
  typedef logic [`ARA_DATA_WIDTH-1:0] elen_t;
  typedef logic [`ARA_TAG_WIDTH-1:0]  tag_t;

  // Request from the host core to every cluster
  typedef struct packed {
    insn_t insn;
    elen_t operand;
    tag_t  tag;
  } acc_req_t;

  // Reduced response back to the host
  typedef struct packed {
    elen_t result;
    logic  error;
    tag_t  tag;
  } acc_resp_t;

endpackage : acc_pkg

`default_nettype wire

/* common/cluster_pkg.sv */
`default_nettype none

`include "ara_settings.svh"

// Types for the cluster side, one lane per cluster
package cluster_pkg;

  import acc_pkg::*;

  // One bit per cluster
  typedef logic [`ARA_NR_CLUSTERS-1:0] cluster_mask_t;

  // Request and response bundles indexed by cluster
  typedef acc_req_t  [`ARA_NR_CLUSTERS-1:0] cluster_req_vec_t;
  typedef acc_resp_t [`ARA_NR_CLUSTERS-1:0] cluster_resp_vec_t;

endpackage : cluster_pkg

`default_nettype wire

/* fork_tree/req_fork_node.sv */
`timescale 1ns/100ps
`default_nettype none

// Registered two-way stream fork
// Holds one request and presents it to each child until that child takes it
module req_fork_node (
  input  wire logic                clk_i,
  input  wire logic                rst_n_i,
  // Upstream side
  input  wire acc_pkg::acc_req_t   req_i,
  input  wire logic                req_valid_i,
  output logic                     req_ready_o,
  // Two children
  output acc_pkg::acc_req_t [1:0]  req_o,
  output logic [1:0]               req_valid_o,
  input  wire logic [1:0]          req_ready_i
);

  import acc_pkg::*;

  acc_req_t   req_q;
  logic [1:0] pending_q;
  logic [1:0] pending_left;
  logic       accept;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // Children that still owe a handshake after this cycle
  assign pending_left = pending_q & ~req_ready_i;

  // Free when nothing stays pending, so back-to-back requests flow
  assign req_ready_o = ~|pending_left;
  assign accept      = req_valid_i & req_ready_o;

  // Each child sees the request only while its bit is set
  assign req_valid_o = pending_q;
  assign req_o       = {2{req_q}};

  //////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 2'b00;
    end else if (accept) begin
      pending_q <= 2'b11;
    end else begin
      pending_q <= pending_left;
    end
  end

  // Payload register
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
  end

endmodule : req_fork_node

`default_nettype wire

/* fork_tree/req_fork_tree.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ara_settings.svh"

// Binary broadcast tree from the host port to every cluster
module req_fork_tree (
  input  wire logic                           clk_i,
  input  wire logic                           rst_n_i,
  // Host request
  input  wire acc_pkg::acc_req_t              acc_req_i,
  input  wire logic                           acc_req_valid_i,
  output logic                                acc_req_ready_o,
  // Cluster requests
  output cluster_pkg::cluster_req_vec_t       cluster_req_o,
  output cluster_pkg::cluster_mask_t          cluster_req_valid_o,
  input  wire cluster_pkg::cluster_mask_t     cluster_req_ready_i
);

  import cluster_pkg::*;

  // Level 0 is the host port, the last level the cluster ports
  // Level l uses only its first 2^l entries
  wire cluster_req_vec_t [`ARA_TREE_LEVELS:0] lvl_req;
  wire cluster_mask_t    [`ARA_TREE_LEVELS:0] lvl_valid;
  wire cluster_mask_t    [`ARA_TREE_LEVELS:0] lvl_ready;

  assign lvl_req[0][0]   = acc_req_i;
  assign lvl_valid[0][0] = acc_req_valid_i;
  assign acc_req_ready_o = lvl_ready[0][0];

  assign cluster_req_o                = lvl_req[`ARA_TREE_LEVELS];
  assign cluster_req_valid_o          = lvl_valid[`ARA_TREE_LEVELS];
  assign lvl_ready[`ARA_TREE_LEVELS]  = cluster_req_ready_i;

  //////////////////////////////////////////////////
  // Fork levels
  //////////////////////////////////////////////////

  for (genvar l = 0; l < `ARA_TREE_LEVELS; l++) begin : gen_level
    for (genvar n = 0; n < (1 << l); n++) begin : gen_node
      req_fork_node i_req_fork_node (
        .clk_i       (clk_i                    ),
        .rst_n_i     (rst_n_i                  ),
        .req_i       (lvl_req[l][n]            ),
        .req_valid_i (lvl_valid[l][n]          ),
        .req_ready_o (lvl_ready[l][n]          ),
        .req_o       (lvl_req[l+1][2*n +: 2]   ),
        .req_valid_o (lvl_valid[l+1][2*n +: 2] ),
        .req_ready_i (lvl_ready[l+1][2*n +: 2] )
      );
    end
  end

  // Unused upper entries of the narrow levels
  for (genvar l = 0; l < `ARA_TREE_LEVELS; l++) begin : gen_unused
    assign lvl_req[l][`ARA_NR_CLUSTERS-1:(1 << l)]   = '0;
    assign lvl_valid[l][`ARA_NR_CLUSTERS-1:(1 << l)] = '0;
    assign lvl_ready[l][`ARA_NR_CLUSTERS-1:(1 << l)] = '0;
  end

endmodule : req_fork_tree

`default_nettype wire

/* join_tree/resp_join_node.sv */
`timescale 1ns/100ps
`default_nettype none

// Registered two-way response join
// Waits for both children and reduces them into one response
module resp_join_node (
  input  wire logic                  clk_i,
  input  wire logic                  rst_n_i,
  // Two children
  input  wire acc_pkg::acc_resp_t [1:0] resp_i,
  input  wire logic [1:0]            resp_valid_i,
  output logic [1:0]                 resp_ready_o,
  // Toward the host
  output acc_pkg::acc_resp_t         resp_o,
  output logic                       resp_valid_o,
  input  wire logic                  resp_ready_i
);

  import acc_pkg::*;

  acc_resp_t resp_d;
  acc_resp_t resp_q;
  logic      valid_q;
  logic      out_free;
  logic      take;

  //////////////////////////////////////////////////
  // Handshake
  //////////////////////////////////////////////////

  // Output register empty or being drained this cycle
  assign out_free = ~valid_q | resp_ready_i;
  assign take     = &resp_valid_i & out_free;

  // Both children are released at the same edge
  assign resp_ready_o = {2{take}};

  assign resp_o       = resp_q;
  assign resp_valid_o = valid_q;

  //////////////////////////////////////////////////
  // Reduction
  //////////////////////////////////////////////////

  always_comb begin
    resp_d.result = resp_i[0].result + resp_i[1].result;
    // Tag mismatch means the children answered different requests
    resp_d.error  = resp_i[0].error | resp_i[1].error | (resp_i[0].tag != resp_i[1].tag);
    resp_d.tag    = resp_i[0].tag;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (take) begin
      valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // Payload register
  always_ff @(posedge clk_i) begin
    if (take) begin
      resp_q <= resp_d;
    end
  end

endmodule : resp_join_node

`default_nettype wire

/* join_tree/resp_join_tree.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ara_settings.svh"

// Binary reduction tree from the cluster responses to the host port
module resp_join_tree (
  input  wire logic                           clk_i,
  input  wire logic                           rst_n_i,
  // Cluster responses
  input  wire cluster_pkg::cluster_resp_vec_t cluster_resp_i,
  input  wire cluster_pkg::cluster_mask_t     cluster_resp_valid_i,
  output cluster_pkg::cluster_mask_t          cluster_resp_ready_o,
  // Host response
  output acc_pkg::acc_resp_t                  acc_resp_o,
  output logic                                acc_resp_valid_o,
  input  wire logic                           acc_resp_ready_i
);

  import cluster_pkg::*;

  // Same level numbering as the fork tree, data flows toward level 0
  wire cluster_resp_vec_t [`ARA_TREE_LEVELS:0] lvl_resp;
  wire cluster_mask_t     [`ARA_TREE_LEVELS:0] lvl_valid;
  wire cluster_mask_t     [`ARA_TREE_LEVELS:0] lvl_ready;

  assign lvl_resp[`ARA_TREE_LEVELS]  = cluster_resp_i;
  assign lvl_valid[`ARA_TREE_LEVELS] = cluster_resp_valid_i;
  assign cluster_resp_ready_o        = lvl_ready[`ARA_TREE_LEVELS];

  assign acc_resp_o       = lvl_resp[0][0];
  assign acc_resp_valid_o = lvl_valid[0][0];
  assign lvl_ready[0][0]  = acc_resp_ready_i;

  //////////////////////////////////////////////////
  // Join levels
  //////////////////////////////////////////////////

  for (genvar l = 0; l < `ARA_TREE_LEVELS; l++) begin : gen_level
    for (genvar n = 0; n < (1 << l); n++) begin : gen_node
      resp_join_node i_resp_join_node (
        .clk_i        (clk_i                    ),
        .rst_n_i      (rst_n_i                  ),
        .resp_i       (lvl_resp[l+1][2*n +: 2]  ),
        .resp_valid_i (lvl_valid[l+1][2*n +: 2] ),
        .resp_ready_o (lvl_ready[l+1][2*n +: 2] ),
        .resp_o       (lvl_resp[l][n]           ),
        .resp_valid_o (lvl_valid[l][n]          ),
        .resp_ready_i (lvl_ready[l][n]          )
      );
    end
  end

  // Unused upper entries of the narrow levels
  for (genvar l = 0; l < `ARA_TREE_LEVELS; l++) begin : gen_unused
    assign lvl_resp[l][`ARA_NR_CLUSTERS-1:(1 << l)]  = '0;
    assign lvl_valid[l][`ARA_NR_CLUSTERS-1:(1 << l)] = '0;
    assign lvl_ready[l][`ARA_NR_CLUSTERS-1:(1 << l)] = '0;
  end

endmodule : resp_join_tree

`default_nettype wire

/* src/cluster_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none

// Command distribution between the host core and the vector clusters
// Requests are broadcast through the fork tree, responses reduced by the join tree
module cluster_dispatch (
  input  wire logic                           clk_i,
  input  wire logic                           rst_n_i,
  // Host request
  input  wire acc_pkg::acc_req_t              acc_req_i,
  input  wire logic                           acc_req_valid_i,
  output logic                                acc_req_ready_o,
  // Host response
  output acc_pkg::acc_resp_t                  acc_resp_o,
  output logic                                acc_resp_valid_o,
  input  wire logic                           acc_resp_ready_i,
  // Cluster requests
  output cluster_pkg::cluster_req_vec_t       cluster_req_o,
  output cluster_pkg::cluster_mask_t          cluster_req_valid_o,
  input  wire cluster_pkg::cluster_mask_t     cluster_req_ready_i,
  // Cluster responses
  input  wire cluster_pkg::cluster_resp_vec_t cluster_resp_i,
  input  wire cluster_pkg::cluster_mask_t     cluster_resp_valid_i,
  output cluster_pkg::cluster_mask_t          cluster_resp_ready_o
);

  //////////////////////////////////////////////////
  // Request broadcast
  //////////////////////////////////////////////////

  req_fork_tree i_req_fork_tree (
    .clk_i               (clk_i               ),
    .rst_n_i             (rst_n_i             ),
    .acc_req_i           (acc_req_i           ),
    .acc_req_valid_i     (acc_req_valid_i     ),
    .acc_req_ready_o     (acc_req_ready_o     ),
    .cluster_req_o       (cluster_req_o       ),
    .cluster_req_valid_o (cluster_req_valid_o ),
    .cluster_req_ready_i (cluster_req_ready_i )
  );

  //////////////////////////////////////////////////
  // Response reduction
  //////////////////////////////////////////////////

  resp_join_tree i_resp_join_tree (
    .clk_i                (clk_i                ),
    .rst_n_i              (rst_n_i              ),
    .cluster_resp_i       (cluster_resp_i       ),
    .cluster_resp_valid_i (cluster_resp_valid_i ),
    .cluster_resp_ready_o (cluster_resp_ready_o ),
    .acc_resp_o           (acc_resp_o           ),
    .acc_resp_valid_o     (acc_resp_valid_o     ),
    .acc_resp_ready_i     (acc_resp_ready_i     )
  );

endmodule : cluster_dispatch

`default_nettype wire

/* tests/cluster_dispatch_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ara_settings.svh"

// Stream handshake properties on the dispatcher ports
module cluster_dispatch_checker (
  input wire logic                          clk_i,
  input wire logic                          rst_n_i,
  input wire acc_pkg::acc_resp_t            acc_resp_o,
  input wire logic                          acc_resp_valid_o,
  input wire logic                          acc_resp_ready_i,
  input wire cluster_pkg::cluster_req_vec_t cluster_req_o,
  input wire cluster_pkg::cluster_mask_t    cluster_req_valid_o,
  input wire cluster_pkg::cluster_mask_t    cluster_req_ready_i
);

  // Host response held until taken
  resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_o))
    else $error("host response changed before it was accepted");

  for (genvar c = 0; c < `ARA_NR_CLUSTERS; c++) begin : gen_cluster
    req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cluster_req_valid_o[c] && !cluster_req_ready_i[c]
      |=> cluster_req_valid_o[c] && $stable(cluster_req_o[c]))
      else $error("request to cluster %0d changed before it was accepted", c);
  end

  // First edge out of reset still sees empty trees
  reset_idle: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !acc_resp_valid_o && cluster_req_valid_o == '0)
    else $error("valid raised in the first cycle after reset");

endmodule : cluster_dispatch_checker

bind cluster_dispatch cluster_dispatch_checker i_checker (.*);

`default_nettype wire

/* tests/cluster_dispatch_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "ara_settings.svh"

module cluster_dispatch_tb;

  import acc_pkg::*;
  import cluster_pkg::*;

  localparam int NC      = `ARA_NR_CLUSTERS;
  localparam int N_RAND  = 300;
  localparam int N_DIR   = 20;
  localparam int TOTAL   = N_RAND + N_DIR;
  localparam int TIMEOUT = 40 * TOTAL + 200;

  logic              clk_i;
  logic              rst_n_i;
  acc_req_t          acc_req_i;
  logic              acc_req_valid_i;
  logic              acc_req_ready_o;
  acc_resp_t         acc_resp_o;
  logic              acc_resp_valid_o;
  logic              acc_resp_ready_i;
  cluster_req_vec_t  cluster_req_o;
  cluster_mask_t     cluster_req_valid_o;
  cluster_mask_t     cluster_req_ready_i;
  cluster_resp_vec_t cluster_resp_i;
  cluster_mask_t     cluster_resp_valid_i;
  cluster_mask_t     cluster_resp_ready_o;

  // Host and cluster model state
  logic [31:0]   lfsr;
  int            cycle_cnt;
  int            sent_cnt;
  int            resp_cnt;
  logic          host_pend;
  logic          directed;
  cluster_mask_t resp_pend;
  int            rx_cnt [NC];
  int            tx_cnt [NC];
  acc_req_t      sent [TOTAL];
  int            acc_cyc [TOTAL];
  int            last_cl_cyc [TOTAL];
  // Error flag in bit 4, tag corruption in bits 3:0
  logic [4:0]    info [NC][TOTAL];

  cluster_dispatch dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
      abort_run();
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
  endfunction

  // n fresh bits, one LFSR step each
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_req(input acc_req_t got, input acc_req_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_resp(input acc_resp_t got, input acc_resp_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_mask(input cluster_mask_t got, input cluster_mask_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %b expected %b", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("mismatch at %0t: %s, got %0d expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Host and cluster models
  //////////////////////////////////////////////////

  task automatic drive_inputs();
    acc_resp_t rsp;
    int        k;
    int        limit;
    // Full speed once the random transactions have drained
    directed = (resp_cnt >= N_RAND);
    limit    = directed ? TOTAL : N_RAND;
    if (!host_pend && sent_cnt < limit && (directed || next_bits(1))) begin
      acc_req_i.insn    = next_bits(32);
      acc_req_i.operand = next_bits(32);
      acc_req_i.tag     = tag_t'(next_bits(4));
      host_pend         = 1'b1;
    end
    acc_req_valid_i  = host_pend;
    acc_resp_ready_i = directed || next_bits(1);
    for (int c = 0; c < NC; c++) begin
      cluster_req_ready_i[c] = directed || next_bits(1);
      k = tx_cnt[c];
      if (!resp_pend[c] && k < rx_cnt[c] && (directed || next_bits(1))) begin
        info[c][k][4]   = (next_bits(4) == 32'hF);
        info[c][k][3:0] = (next_bits(5) == 32'h1F) ? (tag_t'(next_bits(4)) | 4'h1) : 4'h0;
        rsp.result = sent[k].operand ^ (elen_t'(c) << 24);
        rsp.error  = info[c][k][4];
        rsp.tag    = sent[k].tag ^ info[c][k][3:0];
        cluster_resp_i[c] = rsp;
        resp_pend[c]      = 1'b1;
      end
    end
    cluster_resp_valid_i = resp_pend;
  endtask

  // Called just before the rising edge, when every handshake signal is settled
  task automatic sample_transfers();
    acc_resp_t exp;
    int        k;
    if (host_pend && acc_req_ready_o) begin
      sent[sent_cnt]    = acc_req_i;
      acc_cyc[sent_cnt] = cycle_cnt;
      sent_cnt++;
      host_pend = 1'b0;
    end
    for (int c = 0; c < NC; c++) begin
      if (cluster_req_valid_o[c] && cluster_req_ready_i[c]) begin
        k = rx_cnt[c];
        if (k >= sent_cnt) begin
          $display("Cluster %0d received a request that was never sent", c);
          abort_run();
        end
        check_req(cluster_req_o[c], sent[k], $sformatf("request %0d at cluster %0d", k, c));
        if (k >= N_RAND)
          check_count(cycle_cnt, acc_cyc[k] + 3, "request latency through the fork tree");
        rx_cnt[c]++;
      end
      if (resp_pend[c] && cluster_resp_ready_o[c]) begin
        last_cl_cyc[tx_cnt[c]] = cycle_cnt;
        tx_cnt[c]++;
        resp_pend[c] = 1'b0;
      end
    end
    if (acc_resp_valid_o && acc_resp_ready_i) begin
      k = resp_cnt;
      if (k >= sent_cnt) begin
        $display("Host response arrived with no request outstanding");
        abort_run();
      end
      exp.result = '0;
      exp.error  = 1'b0;
      exp.tag    = sent[k].tag ^ info[0][k][3:0];
      // Any tag differing from cluster 0 is flagged somewhere in the tree
      for (int c = 0; c < NC; c++) begin
        exp.result = exp.result + (sent[k].operand ^ (elen_t'(c) << 24));
        exp.error  = exp.error | info[c][k][4] | (info[c][k][3:0] != info[0][k][3:0]);
      end
      check_resp(acc_resp_o, exp, $sformatf("host response %0d", k));
      if (k >= N_RAND)
        check_count(cycle_cnt, last_cl_cyc[k] + 3, "response latency through the join tree");
      resp_cnt++;
    end
  endtask

  initial begin
    lfsr                 = 32'd68;
    cycle_cnt            = 0;
    rst_n_i              = 1'b0;
    acc_req_i            = '0;
    acc_req_valid_i      = 1'b0;
    acc_resp_ready_i     = 1'b0;
    cluster_req_ready_i  = '0;
    cluster_resp_i       = '0;
    cluster_resp_valid_i = '0;
    sent_cnt             = 0;
    resp_cnt             = 0;
    host_pend            = 1'b0;
    resp_pend            = '0;
    directed             = 1'b0;
    for (int c = 0; c < NC; c++) begin
      rx_cnt[c] = 0;
      tx_cnt[c] = 0;
    end
    repeat (2) @(negedge clk_i);
    rst_n_i = 1'b1;
    #1;
    check_bit(acc_req_ready_o, 1'b1, "request ready after reset");
    check_bit(acc_resp_valid_o, 1'b0, "response valid after reset");
    check_mask(cluster_req_valid_o, '0, "cluster request valids after reset");

    while (resp_cnt < TOTAL) begin
      @(negedge clk_i);
      drive_inputs();
      #4;
      sample_transfers();
    end
    // Idle cycles, so a duplicated transfer would still be caught
    repeat (10) begin
      @(negedge clk_i);
      drive_inputs();
      #4;
      sample_transfers();
    end

    for (int c = 0; c < NC; c++) begin
      check_count(rx_cnt[c], TOTAL, $sformatf("requests received by cluster %0d", c));
      check_count(tx_cnt[c], TOTAL, $sformatf("responses sent by cluster %0d", c));
    end
    $display("All checks passed");
    $finish;
  end

endmodule : cluster_dispatch_tb

`default_nettype wire

/* filelist.f */
+incdir+common
common/acc_pkg.sv
common/cluster_pkg.sv
fork_tree/req_fork_node.sv
fork_tree/req_fork_tree.sv
join_tree/resp_join_node.sv
join_tree/resp_join_tree.sv
src/cluster_dispatch.sv
tests/cluster_dispatch_checker.sv
tests/cluster_dispatch_tb.sv

/* Bender.yml */
package:
  name: cluster_dispatch

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/acc_pkg.sv
      - common/cluster_pkg.sv
      - fork_tree/req_fork_node.sv
      - fork_tree/req_fork_tree.sv
      - join_tree/resp_join_node.sv
      - join_tree/resp_join_tree.sv
      - src/cluster_dispatch.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/cluster_dispatch_checker.sv
      - tests/cluster_dispatch_tb.sv
